// ==== design/sad_pkg.sv ====
`default_nettype none

package sad_pkg;

    localparam int SAMPLE_BITS = 8;
    localparam int SAD_BITS = 16;            // top bit doubles as saturation flag
    localparam int COUNT_BITS = 16;
    localparam int REF_INDEX_BITS = 8;       // caps REF_SAMPLES at 256
    localparam int DEFAULT_REF_SAMPLES = 32;

    // edges from the last window sample on adc_data to the trigger pulse
    localparam int TRIGGER_LATENCY = 5;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [SAD_BITS-1:0] sad_t;

    typedef struct packed {
        logic valid;
        logic [REF_INDEX_BITS-1:0] index;
        sample_t sample;
    } ref_write_t;

    typedef struct packed {
        sad_t threshold;
        logic multi_trigger;
    } sad_config_t;

    typedef struct packed {
        sample_t sample;                     // one cycle behind adc_data
        sad_t sample_pos;                    // two cycles behind, zero extended
        sad_t sample_neg;                    // two cycles behind, negated
    } front_t;

    typedef struct packed {
        sample_t ref_sample;
        logic restart;
        logic ready;
    } tap_ctrl_t;

    typedef struct packed {
        logic triggered;
        logic [COUNT_BITS-1:0] count;
    } trig_status_t;

endpackage

`default_nettype wire

// ==== design/sad_sample_front.sv ====
`default_nettype none

// ADC sample front end
// both operand forms are ready before the difference stage, so each tap
// only has to pick one and add the reference, no subtractor in front of a mux
module sad_sample_front (
    input  logic adc_sampleclk,
    input  sad_pkg::sample_t adc_data,
    output sad_pkg::front_t front
);

    sad_pkg::sample_t sample_r;
    sad_pkg::sad_t sample_wide;

    // zero extend to the counter width
    assign sample_wide = sad_pkg::sad_t'(sample_r);

    // stage 1, plain capture of the sample
    always_ff @(posedge adc_sampleclk) begin
        sample_r <= adc_data;
    end

    // stage 2, positive and two's complement forms
    always_ff @(posedge adc_sampleclk) begin
        front.sample_pos <= sample_wide;
        front.sample_neg <= -sample_wide;   // 0 - sample, mod 2**SAD_BITS
    end

    // the compare against the reference happens one stage earlier
    // than the add, so it sees the captured sample directly
    assign front.sample = sample_r;

endmodule

`default_nettype wire

// ==== design/sad_ref_sequencer.sv ====
`default_nettype none

// reference memory plus per-tap control
// tap i sees the reference delayed by i cycles, so every tap runs the same
// waveform but started at a different sample, one window closes per cycle
module sad_ref_sequencer #(
    parameter int REF_SAMPLES = sad_pkg::DEFAULT_REF_SAMPLES
) (
    input  logic adc_sampleclk,
    input  logic reset,
    input  logic armed,
    input  logic active,
    input  sad_pkg::ref_write_t ref_wr,
    output sad_pkg::tap_ctrl_t [REF_SAMPLES-1:0] taps
);

    localparam int PHASE_BITS = $clog2(REF_SAMPLES);

    // restart is used at the accumulate stage, three edges after the
    // matching ref sample leaves this block
    localparam int RESTART_LEAD = 3;
    localparam logic [REF_SAMPLES-1:0] RESTART_START =
        REF_SAMPLES'(1) << (REF_SAMPLES - RESTART_LEAD);

    localparam logic [PHASE_BITS-1:0] LAST_PHASE = PHASE_BITS'(REF_SAMPLES - 1);

    sad_pkg::sample_t ref_mem [REF_SAMPLES];
    sad_pkg::sample_t ref_chain [REF_SAMPLES];

    logic [PHASE_BITS-1:0] phase;
    logic [REF_SAMPLES-1:0] restart;      // one-hot, rotates one tap per cycle
    logic [REF_SAMPLES-1:0] ready;        // thermometer, fills after first pass
    logic run;

    assign run = armed && active;

    // out-of-range indices are dropped
    always_ff @(posedge adc_sampleclk) begin
        if (ref_wr.valid && (ref_wr.index < REF_SAMPLES)) begin
            ref_mem[ref_wr.index[PHASE_BITS-1:0]] <= ref_wr.sample;
        end
    end

    // reference delay chain
    always_ff @(posedge adc_sampleclk) begin
        ref_chain[0] <= ref_mem[phase];
        for (int i = 1; i < REF_SAMPLES; i++) begin
            ref_chain[i] <= ref_chain[i-1];
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            phase <= '0;
            ready <= '0;
            restart <= RESTART_START;
        end else begin
            phase <= phase + 1'b1;          // wraps, REF_SAMPLES is a power of two
            restart <= {restart[REF_SAMPLES-2:0], restart[REF_SAMPLES-1]};
            // tap 0 goes ready at the end of the first pass and stays there
            ready <= {ready[REF_SAMPLES-2:0], ready[0] | (phase == LAST_PHASE)};
        end
    end

    always_comb begin
        for (int i = 0; i < REF_SAMPLES; i++) begin
            taps[i].ref_sample = ref_chain[i];
            taps[i].restart = restart[i];
            taps[i].ready = ready[i];
        end
    end

    // exactly one tap restarts, and it trails the phase by RESTART_LEAD taps,
    // otherwise the bank would merge, lose or misalign windows
    restart_one_hot : assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        $onehot(restart) && restart[phase - PHASE_BITS'(RESTART_LEAD)]
    ) else $error("restart vector out of step at phase %0d: %b", phase, restart);

endmodule

`default_nettype wire

// ==== design/sad_accumulator_bank.sv ====
`default_nettype none

// per-tap SAD counters, threshold compare and trigger merge
module sad_accumulator_bank #(
    parameter int REF_SAMPLES = sad_pkg::DEFAULT_REF_SAMPLES
) (
    input  logic adc_sampleclk,
    input  logic reset,
    input  logic armed,
    input  logic clear_status,
    input  sad_pkg::sad_config_t cfg,
    input  sad_pkg::front_t front,
    input  sad_pkg::tap_ctrl_t [REF_SAMPLES-1:0] taps,
    output logic trigger,
    output sad_pkg::trig_status_t status
);

    logic [REF_SAMPLES-1:0] match;
    logic armed_r;
    logic blocked;

    for (genvar i = 0; i < REF_SAMPLES; i++) begin : g_tap
        logic decision;                   // sample above reference
        sad_pkg::sample_t ref_r;
        sad_pkg::sad_t incr;
        sad_pkg::sad_t sad;
        logic hit;

        always_ff @(posedge adc_sampleclk) begin
            decision <= front.sample > taps[i].ref_sample;
            ref_r <= taps[i].ref_sample;   // lines up with sample_pos/neg

            // absolute difference
            if (decision) begin
                incr <= front.sample_pos - sad_pkg::sad_t'(ref_r);
            end else begin
                incr <= front.sample_neg + sad_pkg::sad_t'(ref_r);
            end

            // first sample of a window reloads, otherwise add until saturated
            if (taps[i].restart) begin
                sad <= incr;
            end else if (!sad[sad_pkg::SAD_BITS-1]) begin
                sad <= sad + incr;
            end
        end

        // restart here marks the counter as holding a complete window
        always_ff @(posedge adc_sampleclk) begin
            if (reset) begin
                hit <= 1'b0;
            end else begin
                hit <= (sad <= cfg.threshold) && taps[i].restart && taps[i].ready;
            end
        end

        assign match[i] = hit;
    end

    // single-trigger mode, also covers a pulse still on its way into status
    assign blocked = !cfg.multi_trigger && (status.triggered || trigger);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger <= 1'b0;
        end else begin
            trigger <= |match && !blocked;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            armed_r <= 1'b0;
            status <= '0;
        end else begin
            armed_r <= armed;
            if (clear_status || (armed && !armed_r)) begin   // clear wins over a pulse
                status <= '0;
            end else if (trigger) begin
                status.triggered <= 1'b1;
                if (status.count != '1) begin
                    status.count <= status.count + 1'b1;
                end
            end
        end
    end

    // once status shows a pulse, no pulse may be on the output at the same time,
    // which also catches a second pulse right behind the first
    single_trigger_holds : assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (status.triggered && !cfg.multi_trigger) |-> !trigger
    ) else $error("trigger fired again in single-trigger mode");

endmodule

`default_nettype wire

// ==== design/sad_trigger_top.sv ====
`default_nettype none

// SAD trigger on the ADC sample stream
module sad_trigger_top #(
    parameter int REF_SAMPLES = sad_pkg::DEFAULT_REF_SAMPLES
) (
    input  logic adc_sampleclk,
    input  logic reset,
    input  sad_pkg::sample_t adc_data,
    input  logic armed,
    input  logic active,
    input  sad_pkg::ref_write_t ref_wr,
    input  sad_pkg::sad_config_t cfg,
    input  logic clear_status,
    output logic trigger,
    output sad_pkg::trig_status_t status
);

    sad_pkg::front_t front;
    sad_pkg::tap_ctrl_t [REF_SAMPLES-1:0] taps;

    sad_sample_front sad_sample_front_i (
        .adc_sampleclk (adc_sampleclk),
        .adc_data      (adc_data),
        .front         (front)
    );

    sad_ref_sequencer #(.REF_SAMPLES(REF_SAMPLES)) sad_ref_sequencer_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .armed         (armed),
        .active        (active),
        .ref_wr        (ref_wr),
        .taps          (taps)
    );

    // armed only feeds the status clear here
    sad_accumulator_bank #(.REF_SAMPLES(REF_SAMPLES)) sad_accumulator_bank_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .armed         (armed),
        .clear_status  (clear_status),
        .cfg           (cfg),
        .front         (front),
        .taps          (taps),
        .trigger       (trigger),
        .status        (status)
    );

endmodule

`default_nettype wire

// ==== verif/sad_tb.sv ====
`default_nettype none

module sad_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = 32;
    localparam int TEST_CYCLES = 2000;
    localparam int MARGIN = 500;

    logic adc_sampleclk;
    logic reset;
    sad_pkg::sample_t adc_data;
    logic armed;
    logic active;
    sad_pkg::ref_write_t ref_wr;
    sad_pkg::sad_config_t cfg;
    logic clear_status;
    logic trigger;
    sad_pkg::trig_status_t status;

    // values applied on the next drive_cycle
    logic cur_reset, cur_armed, cur_active, cur_clr, prev_armed, prev_run;
    sad_pkg::sad_config_t cur_cfg;
    sad_pkg::ref_write_t cur_wr;

    sad_pkg::sample_t ref_wave [N];
    sad_pkg::sample_t hist [$];      // samples since the run began
    bit cand [0:8191];               // window match, indexed by trigger edge
    bit rst_ev [0:8191];
    bit clr_ev [0:8191];
    bit mt_ev [0:8191];
    int edge_n = 0;
    int errors = 0;
    int checks = 0;

    // model of trigger and status
    logic m_trig, st_trig, blocked, new_trig;
    logic [sad_pkg::COUNT_BITS-1:0] st_cnt;

    sad_trigger_top #(.REF_SAMPLES(N)) sad_trigger_top_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_data      (adc_data),
        .armed         (armed),
        .active        (active),
        .ref_wr        (ref_wr),
        .cfg           (cfg),
        .clear_status  (clear_status),
        .trigger       (trigger),
        .status        (status)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #10 adc_sampleclk = ~adc_sampleclk;
    end

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // SAD of the newest N samples, held once the top bit is set
    function automatic int window_sad();
        logic [sad_pkg::SAD_BITS-1:0] sum;
        int a;
        int b;
        sum = '0;
        for (int i = 0; i < N; i++) begin
            a = int'(hist[hist.size() - N + i]);
            b = int'(ref_wave[i]);
            if (!sum[sad_pkg::SAD_BITS-1]) sum += (a > b) ? a - b : b - a;
        end
        return int'(sum);
    endfunction

    task automatic drive_cycle(input sad_pkg::sample_t s);
        logic run;
        @(posedge adc_sampleclk);
        edge_n++;
        adc_data <= s;
        reset <= cur_reset;
        armed <= cur_armed;
        active <= cur_active;
        cfg <= cur_cfg;
        clear_status <= cur_clr;
        ref_wr <= cur_wr;
        rst_ev[edge_n+1] = cur_reset;
        clr_ev[edge_n+1] = cur_clr || (cur_armed && !prev_armed);
        mt_ev[edge_n+1] = cur_cfg.multi_trigger;
        prev_armed = cur_armed;
        run = cur_armed && cur_active && !cur_reset;
        if (run) begin
            hist.push_back(s);
            if (hist.size() > N) void'(hist.pop_front());
            if (hist.size() == N && window_sad() <= int'(cur_cfg.threshold))
                cand[edge_n + 1 + sad_pkg::TRIGGER_LATENCY] = 1'b1;
        end else begin
            // windows still in the pipeline lose their ready bit
            if (prev_run) for (int e = edge_n + 3; e <= edge_n + 6; e++) cand[e] = 1'b0;
            hist.delete();
        end
        prev_run = run;
        cur_clr = 1'b0;
        cur_wr = '0;
    endtask

    task automatic play_noise(input int n);
        repeat (n) drive_cycle(sad_pkg::sample_t'($urandom));
    endtask

    task automatic play_wave(input int dmax);
        int v;
        for (int i = 0; i < N; i++) begin
            v = int'(ref_wave[i]) + int'($urandom % (2 * dmax + 1)) - dmax;
            if (v < 0) v = 0;
            if (v > 255) v = 255;
            drive_cycle(sad_pkg::sample_t'(v));
        end
    endtask

    task automatic write_ref(input bit zero);
        for (int i = 0; i < N; i++) begin
            ref_wave[i] = zero ? '0 : sad_pkg::sample_t'($urandom);
            cur_wr = '{valid: 1'b1, index: 8'(i), sample: ref_wave[i]};
            drive_cycle('0);
        end
    endtask

    task automatic arm(input int thr, input bit multi);
        cur_cfg = '{threshold: sad_pkg::sad_t'(thr), multi_trigger: multi};
        drive_cycle('0);               // cfg settles before the run
        cur_armed = 1'b1;
        cur_active = 1'b1;
    endtask

    task automatic disarm();
        cur_armed = 1'b0;
        cur_active = 1'b0;
        play_noise(10);
    endtask

    // compares every cycle, after the edge has settled
    always @(negedge adc_sampleclk) begin
        if (edge_n > 0) begin
            if (rst_ev[edge_n]) begin
                m_trig = 1'b0;
                st_trig = 1'b0;
                st_cnt = '0;
            end else begin
                blocked = !mt_ev[edge_n] && (st_trig || m_trig);
                new_trig = cand[edge_n] && !blocked;
                if (clr_ev[edge_n]) begin
                    st_trig = 1'b0;
                    st_cnt = '0;
                end else if (m_trig) begin
                    st_trig = 1'b1;
                    if (st_cnt != '1) st_cnt++;
                end
                m_trig = new_trig;
            end
            check_val(32'(trigger), 32'(m_trig), "trigger");
            check_val(32'(status.triggered), 32'(st_trig), "status.triggered");
            check_val(32'(status.count), 32'(st_cnt), "status.count");
        end
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 20);
        $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(2));
        reset = 1'b1;
        adc_data = '0;
        armed = 1'b0;
        active = 1'b0;
        ref_wr = '0;
        cfg = '0;
        clear_status = 1'b0;
        cur_reset = 1'b1;
        cur_armed = 1'b0;
        cur_active = 1'b0;
        cur_clr = 1'b0;
        cur_cfg = '0;
        cur_wr = '0;
        prev_armed = 1'b0;
        prev_run = 1'b0;
        rst_ev[1] = 1'b1;
        repeat (15) drive_cycle('0);
        cur_reset = 1'b0;
        write_ref(0);

        arm(0, 1);                     // exact match amid noise
        play_noise(40);
        play_wave(0);
        play_noise(40);
        disarm();

        arm(40, 1);                    // near matches, small perturbation
        repeat (6) begin
            play_noise(20 + int'($urandom % 20));
            play_wave(2);
        end
        disarm();

        arm(0, 1);                     // three pulses
        repeat (3) begin
            play_wave(0);
            play_noise(30);
        end
        @(negedge adc_sampleclk);
        check_val(32'(status.count), 3, "count after three copies");
        disarm();

        arm(0, 0);                     // single-trigger mode
        repeat (3) begin
            play_wave(0);
            play_noise(30);
        end
        @(negedge adc_sampleclk);
        check_val(32'(status.count), 1, "count in single mode");
        disarm();
        arm(0, 0);
        play_wave(0);
        play_noise(20);
        disarm();

        arm(0, 1);                     // status clear, then idle run
        play_wave(0);
        play_noise(10);
        cur_clr = 1'b1;
        play_noise(3);
        @(negedge adc_sampleclk);
        check_val(32'(status.count), 0, "count after clear");
        cur_active = 1'b0;
        play_wave(0);
        play_noise(10);
        disarm();

        write_ref(1);                  // all-zero reference, data at full scale
        arm(N * 255 - 1, 1);
        repeat (100) drive_cycle(8'hff);
        disarm();
        arm(16'h7fff, 1);              // warm-up window
        play_noise(60);
        disarm();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/sad_pkg.sv
design/sad_sample_front.sv
design/sad_ref_sequencer.sv
design/sad_accumulator_bank.sv
design/sad_trigger_top.sv
verif/sad_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= sad_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
